// ==== fixed_point_pkg.sv ====
// fixed-point word width, fraction position, step counter width, saturation value and word types
package fixed_point_pkg;

    // word width and fraction bits
    localparam int WIDTH = 16;
    localparam int FRAC  = 8;

    // enough bits to count the WIDTH shift-add steps
    localparam int STEP_WIDTH = $clog2(WIDTH + 1);

    // signed operand or result word
    typedef logic signed [WIDTH-1:0] word_t;

    // unsigned magnitude after sign removal
    typedef logic [WIDTH-1:0] mag_t;

    // full unsigned product of two magnitudes
    typedef logic [2*WIDTH-1:0] prod_t;

    // largest positive word, used as the saturation value
    localparam word_t MAX_MAG = word_t'((1 << (WIDTH - 1)) - 1);

endpackage

// ==== tdm_pkg.sv ====
// unit count, index width, scheduler state type and operand array type
package tdm_pkg;

    import fixed_point_pkg::*;

    // operand pairs sharing the multiplier
    localparam int NUM_UNITS = 4;

    // index width, never below one bit
    localparam int IDX_WIDTH = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

    typedef logic [IDX_WIDTH-1:0] idx_t;

    // sweep state machine
    typedef enum logic [1:0] {
        IDLE = 2'h0,
        CALC = 2'h1,
        DONE = 2'h2
    } sched_state_t;

    // one word per unit
    typedef word_t word_array_t [NUM_UNITS];

endpackage

// ==== shift_add_core.sv ====
// multi-cycle unsigned shift-add multiplier core with ready, done and overflow
`timescale 1ns/10ps

module shift_add_core
    import fixed_point_pkg::*;
(
    input  logic  ctl_clk,
    input  logic  ctl_rst,
    input  logic  trigger,
    input  mag_t  a,
    input  mag_t  b,
    output prod_t y,
    output logic  ready,
    output logic  done,
    output logic  overflow
);

    // multiplier bits consumed LSB first
    mag_t                  mplr;
    // multiplicand, shifted up one place per step
    prod_t                 mcand;
    prod_t                 acc;
    logic [STEP_WIDTH-1:0] step;

    // control state
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            ready <= 1'b1;
            done  <= 1'b0;
            step  <= '0;
        end else begin
            done <= 1'b0;
            if (trigger && ready) begin
                ready <= 1'b0;
                step  <= '0;
            end else if (!ready) begin
                step <= step + 1'b1;
                // last add lands on this edge
                if (step == STEP_WIDTH'(WIDTH - 1)) begin
                    ready <= 1'b1;
                    done  <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge ctl_clk) begin
        if (trigger && ready) begin
            mplr  <= a;
            mcand <= prod_t'(b);
            acc   <= '0;
        end else if (!ready) begin
            if (mplr[0]) begin
                acc <= acc + mcand;
            end
            mplr  <= mplr >> 1;
            mcand <= mcand << 1;
        end
    end

    assign y = acc;

    // anything above the selected fixed-point slice cannot be represented
    assign overflow = |acc[2*WIDTH-1:WIDTH+FRAC];

    // the scheduler must wait for ready before triggering
    trigger_needs_ready: assert property (
        @(posedge ctl_clk) disable iff (!ctl_rst)
        trigger |-> ready
    );

    done_single_cycle: assert property (
        @(posedge ctl_clk) disable iff (!ctl_rst)
        done |=> !done
    );

endmodule

// ==== fixed_mul_unit.sv ====
// signed fixed-point multiplier unit: sign removal, shift-add core, saturation, sign restore
`timescale 1ns/10ps

module fixed_mul_unit
    import fixed_point_pkg::*;
(
    input  logic  ctl_clk,
    input  logic  ctl_rst,
    input  logic  trigger,
    input  word_t op_a,
    input  word_t op_b,
    output word_t result,
    output logic  ready,
    output logic  calc_done
);

    mag_t  mag_a;
    mag_t  mag_b;
    prod_t prod;
    logic  core_ovf;
    logic  neg_q;
    mag_t  slice;
    logic  saturate;
    mag_t  clipped;

    // two's complement negate when neg is set
    function automatic mag_t cond_negate(input logic neg, input mag_t value);
        mag_t negated;
        negated = mag_t'(~value + 1'b1);
        return neg ? negated : value;
    endfunction

    assign mag_a = cond_negate(op_a[WIDTH-1], mag_t'(op_a));
    assign mag_b = cond_negate(op_b[WIDTH-1], mag_t'(op_b));

    // product sign, held with the operation it belongs to
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            neg_q <= 1'b0;
        end else if (trigger) begin
            neg_q <= op_a[WIDTH-1] ^ op_b[WIDTH-1];
        end
    end

    shift_add_core core_i (
        .ctl_clk  (ctl_clk),
        .ctl_rst  (ctl_rst),
        .trigger  (trigger),
        .a        (mag_a),
        .b        (mag_b),
        .y        (prod),
        .ready    (ready),
        .done     (calc_done),
        .overflow (core_ovf)
    );

    // drop FRAC fraction bits, truncation toward zero on the magnitude
    assign slice = prod[FRAC+WIDTH-1:FRAC];

    // top slice bit set means the magnitude reaches the sign bit
    assign saturate = core_ovf | slice[WIDTH-1];
    assign clipped  = saturate ? mag_t'(MAX_MAG) : slice;

    assign result = word_t'(cond_negate(neg_q, clipped));

endmodule

// ==== tdm_scheduler.sv ====
// sweep state machine, unit index counter and multiplier trigger generation
`timescale 1ns/10ps

module tdm_scheduler
    import tdm_pkg::*;
(
    input  logic ctl_clk,
    input  logic ctl_rst,
    input  logic main_clk,
    input  logic ready,
    input  logic calc_done,
    output idx_t idx,
    output logic trigger,
    output logic busy
);

    sched_state_t state;
    // one multiply issued and not yet finished
    logic         in_flight;
    logic         last_unit;

    assign last_unit = (idx == idx_t'(NUM_UNITS - 1));

    // sweep control
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // start on the first cycle the slow clock is seen high
                    if (main_clk) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    if (calc_done && last_unit) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // hold the products until main_clk drops
                    if (!main_clk) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // index advances as each result is stored, wraps after the last unit
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            idx <= '0;
        end else if (calc_done) begin
            idx <= last_unit ? '0 : idx + 1'b1;
        end
    end

    // one trigger per index
    always_ff @(posedge ctl_clk) begin
        if (!ctl_rst) begin
            trigger   <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            trigger <= (state == CALC) && ready && !in_flight;
            if ((state == CALC) && ready && !in_flight) begin
                in_flight <= 1'b1;
            end else if (calc_done) begin
                in_flight <= 1'b0;
            end
        end
    end

    assign busy = (state == CALC);

    idx_in_range: assert property (
        @(posedge ctl_clk) disable iff (!ctl_rst)
        idx < NUM_UNITS
    );

    // a result only comes back for a multiply this scheduler issued
    done_while_in_flight: assert property (
        @(posedge ctl_clk) disable iff (!ctl_rst)
        calc_done |-> in_flight
    );

endmodule

// ==== unit_bank.sv ====
// operand selection by unit index and per-unit product registers
`timescale 1ns/10ps

module unit_bank
    import fixed_point_pkg::*;
    import tdm_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_rst,
    input  word_array_t multiplicands,
    input  word_array_t multipliers,
    input  idx_t        idx,
    input  word_t       result,
    input  logic        calc_done,
    output word_t       op_a,
    output word_t       op_b,
    output word_array_t products
);

    logic [NUM_UNITS-1:0] wr_en;

    // operand pair for the unit being served
    assign op_a = multiplicands[idx];
    assign op_b = multipliers[idx];

    for (genvar i = 0; i < NUM_UNITS; i++) begin : unit
        assign wr_en[i] = calc_done && (idx == idx_t'(i));

        // each product holds until the next sweep reaches this unit
        always_ff @(posedge ctl_clk) begin
            if (!ctl_rst) begin
                products[i] <= '0;
            end else if (wr_en[i]) begin
                products[i] <= result;
            end
        end
    end

endmodule

// ==== tdm_mul_top.sv ====
// top level of the time-division multiplexed fixed-point multiplier
`timescale 1ns/10ps

module tdm_mul_top
    import fixed_point_pkg::*;
    import tdm_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_rst,
    input  logic        main_clk,
    input  word_array_t multiplicands,
    input  word_array_t multipliers,
    output word_array_t products,
    output logic        busy
);

    idx_t  idx;
    logic  trigger;
    logic  ready;
    logic  calc_done;
    word_t op_a;
    word_t op_b;
    word_t result;

    tdm_scheduler sched_i (
        .ctl_clk   (ctl_clk),
        .ctl_rst   (ctl_rst),
        .main_clk  (main_clk),
        .ready     (ready),
        .calc_done (calc_done),
        .idx       (idx),
        .trigger   (trigger),
        .busy      (busy)
    );

    unit_bank bank_i (
        .ctl_clk       (ctl_clk),
        .ctl_rst       (ctl_rst),
        .multiplicands (multiplicands),
        .multipliers   (multipliers),
        .idx           (idx),
        .result        (result),
        .calc_done     (calc_done),
        .op_a          (op_a),
        .op_b          (op_b),
        .products      (products)
    );

    // single shared multiplier
    fixed_mul_unit mul_i (
        .ctl_clk   (ctl_clk),
        .ctl_rst   (ctl_rst),
        .trigger   (trigger),
        .op_a      (op_a),
        .op_b      (op_b),
        .result    (result),
        .ready     (ready),
        .calc_done (calc_done)
    );

endmodule

// ==== tb_tdm_mul.sv ====
// testbench for the TDM fixed-point multiplier with file frames, a random frame and a reference model
`timescale 1ns/10ps

module tb_tdm_mul
    import fixed_point_pkg::*;
    import tdm_pkg::*;
();

    localparam int WAIT_LIMIT  = 2000;
    localparam int HOLD_CYCLES = 24;

    logic        ctl_clk;
    logic        ctl_rst;
    logic        main_clk;
    word_array_t multiplicands;
    word_array_t multipliers;
    word_array_t products;
    logic        busy;

    // operands and expected products of the frame under test
    word_array_t case_a;
    word_array_t case_b;
    word_array_t case_exp;

    integer fd;
    integer seed;
    int     tests_passed;
    int     tests_failed;
    int     error_count;

    tdm_mul_top dut_i (
        .ctl_clk       (ctl_clk),
        .ctl_rst       (ctl_rst),
        .main_clk      (main_clk),
        .multiplicands (multiplicands),
        .multipliers   (multipliers),
        .products      (products),
        .busy          (busy)
    );

    always #5 ctl_clk = ~ctl_clk;

    // magnitude product with fraction bits dropped toward zero, clipped and then signed
    function automatic word_t model_product(input word_t a, input word_t b);
        longint mag_a;
        longint mag_b;
        longint mag_p;
        logic   neg;
        mag_a = (a < 0) ? -longint'(a) : longint'(a);
        mag_b = (b < 0) ? -longint'(b) : longint'(b);
        mag_p = (mag_a * mag_b) >> FRAC;
        if (mag_p >= (longint'(1) << (WIDTH - 1))) begin
            mag_p = (longint'(1) << (WIDTH - 1)) - 1;
        end
        neg = (a < 0) ^ (b < 0);
        return neg ? word_t'(-mag_p) : word_t'(mag_p);
    endfunction

    // polls busy on the falling edge until it reaches level
    task automatic wait_busy(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        while ((busy !== level) && (cycles < WAIT_LIMIT)) begin
            @(negedge ctl_clk);
            cycles++;
        end
        ok = (busy === level);
        if (!ok) begin
            $display("timeout: busy did not go %s within %0d cycles",
                     level ? "high" : "low", WAIT_LIMIT);
        end
    endtask

    task automatic compare_products(input string name, inout int errors);
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (products[i] !== case_exp[i]) begin
                $display("ERROR t=%0t %s unit %0d: product %h, expected %h",
                         $time, name, i, products[i], case_exp[i]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors);
            tests_failed++;
        end
        error_count += errors;
    endtask

    // reads the next NUM_UNITS data lines of the cases file and skips comments and blank lines
    task automatic read_frame(output int found);
        string            line;
        integer           code;
        logic [WIDTH-1:0] raw_a;
        logic [WIDTH-1:0] raw_b;
        logic [WIDTH-1:0] raw_exp;
        found = 0;
        while ((found < NUM_UNITS) && !$feof(fd)) begin
            code = $fgets(line, fd);
            if ((code > 0) && (line.getc(0) != "#")) begin
                if ($sscanf(line, "%h %h %h", raw_a, raw_b, raw_exp) == 3) begin
                    case_a[found]   = word_t'(raw_a);
                    case_b[found]   = word_t'(raw_b);
                    case_exp[found] = word_t'(raw_exp);
                    found++;
                end
            end
        end
    endtask

    // one sweep and then a hold phase with main_clk still high and the operands changed
    task automatic run_frame(input string name);
        int   errors;
        logic ok;
        errors = 0;
        @(negedge ctl_clk);
        for (int i = 0; i < NUM_UNITS; i++) begin
            multiplicands[i] = case_a[i];
            multipliers[i]   = case_b[i];
        end
        main_clk = 1'b1;
        wait_busy(1'b1, ok);
        if (ok) begin
            wait_busy(1'b0, ok);
        end
        if (ok) begin
            compare_products(name, errors);
            for (int i = 0; i < NUM_UNITS; i++) begin
                multiplicands[i] = ~case_a[i];
                multipliers[i]   = ~case_b[i];
            end
            repeat (HOLD_CYCLES) begin
                @(negedge ctl_clk);
                if (busy !== 1'b0) begin
                    $display("ERROR t=%0t %s: busy is high while main_clk stays high",
                             $time, name);
                    errors++;
                end
            end
            compare_products(name, errors);
        end
        main_clk = 1'b0;
        repeat (3) @(negedge ctl_clk);
        if (ok) begin
            report_test(name, errors);
        end else begin
            $display("test %s: failed because the sweep did not complete", name);
            tests_failed++;
        end
    endtask

    initial begin
        int          found;
        int          frame;
        int          errors;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        ctl_clk      = 1'b0;
        ctl_rst      = 1'b0;
        main_clk     = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        error_count  = 0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            multiplicands[i] = '0;
            multipliers[i]   = '0;
        end
        repeat (16) @(negedge ctl_clk);
        ctl_rst = 1'b1;
        @(negedge ctl_clk);

        // idle outputs straight after reset
        errors = 0;
        if (busy !== 1'b0) begin
            $display("ERROR t=%0t reset state: busy is %b", $time, busy);
            errors++;
        end
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (products[i] !== '0) begin
                $display("ERROR t=%0t reset state unit %0d: product %h, expected 0000",
                         $time, i, products[i]);
                errors++;
            end
        end
        report_test("reset state", errors);

        fd = $fopen("tdm_mul_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tdm_mul_cases.txt, no file frames were run");
            tests_failed++;
        end else begin
            frame = 0;
            read_frame(found);
            while (found == NUM_UNITS) begin
                frame++;
                run_frame($sformatf("frame %0d", frame));
                read_frame(found);
            end
            if (found != 0) begin
                $display("the cases file ends in the middle of a frame");
                tests_failed++;
            end
            if (frame == 0) begin
                $display("the cases file holds no complete frame");
                tests_failed++;
            end
            $fclose(fd);
        end

        // random operands with multipliers scaled down so only some products clip
        seed = 32'h0ba43400;
        for (int i = 0; i < NUM_UNITS; i++) begin
            rnd_a       = $random(seed);
            rnd_b       = $random(seed);
            case_a[i]   = word_t'(rnd_a[WIDTH-1:0]);
            case_b[i]   = word_t'(rnd_b[WIDTH-1:0]) >>> rnd_b[18:16];
            case_exp[i] = model_product(case_a[i], case_b[i]);
        end
        run_frame("random frame");

        $display("tests passed %0d, tests failed %0d, value errors %0d",
                 tests_passed, tests_failed, error_count);
        if ((tests_failed == 0) && (error_count == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tdm_mul_cases.txt ====
# TDM multiplier cases, Q8.8 words in hex, one unit per line, four lines per frame
# columns: multiplicand multiplier expected_product
# mixed signs: 1.5*2.0, -1.5*0.5, -2.25*-3.0, 0*-5.0
0180 0200 0300
fe80 0080 ff40
fdc0 fd00 06c0
0000 fb00 0000

# truncation toward zero and largest product below saturation
0001 0001 0000
fffd 0055 0000
0123 ff01 fedf
7fff 0100 7fff

# saturation, same and different signs
7fff 7fff 7fff
8000 0200 8001
8000 8000 7fff
4000 fe00 8001

# new operands replacing every product
0100 0100 0100
ff00 0300 fd00
0040 0040 0010
0200 ff80 ff00

# near the limit and small magnitudes
0a00 0c80 7d00
f600 0d00 8001
00ff 00ff 00fe
ff81 ff81 003f

// ==== sources.f ====
fixed_point_pkg.sv
tdm_pkg.sv
shift_add_core.sv
fixed_mul_unit.sv
tdm_scheduler.sv
unit_bank.sv
tdm_mul_top.sv
tb_tdm_mul.sv
